// ==== verilog/decode_pkg.sv ====
package decode_pkg;

    localparam int INST_W  = 32;
    localparam int REG_W   = 5;
    localparam int ECODE_W = 6;
    localparam int SUB_W   = 4;

    typedef logic [INST_W-1:0]  inst_t;
    typedef logic [INST_W-1:0]  addr_t;
    typedef logic [REG_W-1:0]   reg_idx_t;
    typedef logic [INST_W-1:0]  imm_t;
    typedef logic [ECODE_W-1:0] excp_code_t;
    typedef logic [SUB_W-1:0]   sub_op_t;

    // Unit numbering kept compatible with the core's existing codes
    typedef enum logic [3:0] {
        UNIT_ALU    = 4'd0,
        UNIT_BRANCH = 4'd1,
        UNIT_EXCP   = 4'd3,
        UNIT_MEM    = 4'd5,
        UNIT_LINK   = 4'd8     // JIRL and BL act as ALU plus branch
    } unit_e;

    typedef enum logic [3:0] {
        ALU_AND, ALU_OR, ALU_NOR, ALU_XOR, ALU_ADD, ALU_SUB, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS1, ALU_PASS2
    } alu_op_e;

    typedef enum logic {
        SRC1_REG,
        SRC1_PC
    } src1_e;

    typedef enum logic [1:0] {
        SRC2_REG,
        SRC2_IMM,
        SRC2_RD,               // Branch compares rj with rd
        SRC2_FOUR              // Link value
    } src2_e;

    typedef struct packed {
        unit_e   unit;
        sub_op_t sub_op;
        alu_op_e alu_op;
        src1_e   src1;
        src2_e   src2;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    redirect;
    } decode_ctrl_t;

    typedef struct packed {
        logic         hit;
        decode_ctrl_t ctrl;
        imm_t         imm;
        reg_idx_t     rj;
        reg_idx_t     rk;
        reg_idx_t     rd;
    } class_out_t;

    typedef struct packed {
        logic         nop;
        decode_ctrl_t ctrl;
        reg_idx_t     rj;
        reg_idx_t     rk;
        reg_idx_t     rd;
        imm_t         imm;
        excp_code_t   excp_code;
        logic         excp_sub;
    } decode_out_t;

    localparam excp_code_t ECODE_ADE = 6'd8;
    localparam excp_code_t ECODE_SYS = 6'd11;
    localparam excp_code_t ECODE_BRK = 6'd12;
    localparam excp_code_t ECODE_INE = 6'd13;

    localparam logic [5:0]  OP_MEM     = 6'b001010;
    localparam logic [16:0] OP_SYSCALL = 17'b0000000000_1010110;
    localparam logic [16:0] OP_BREAK   = 17'b0000000000_1010100;
    localparam reg_idx_t    LINK_REG   = 5'd1;

endpackage

// ==== verilog/alu_decode.sv ====
`timescale 1ns/10ps

module alu_decode
    import decode_pkg::*;
(
    input  inst_t      ir,
    output class_out_t result
);

    imm_t ui5;
    imm_t si12;
    imm_t ui12;
    imm_t ui20;

    assign ui5  = {27'b0, ir[14:10]};          // Shift amount
    assign si12 = {{20{ir[21]}}, ir[21:10]};
    assign ui12 = {20'b0, ir[21:10]};          // Logic ops zero-extend
    assign ui20 = {ir[24:5], 12'b0};

    always_comb
    begin
        result                = '0;
        result.hit            = 1'b1;
        result.ctrl.unit      = UNIT_ALU;
        result.ctrl.reg_write = 1'b1;
        result.ctrl.src2      = SRC2_IMM;
        result.rj             = ir[9:5];
        result.rd             = ir[4:0];
        casez (ir[31:15])
            17'b0000000000_0100000: result.ctrl.alu_op = ALU_ADD;   // ADD.W
            17'b0000000000_0100010: result.ctrl.alu_op = ALU_SUB;   // SUB.W
            17'b0000000000_0100100: result.ctrl.alu_op = ALU_SLT;
            17'b0000000000_0100101: result.ctrl.alu_op = ALU_SLTU;
            17'b0000000000_0101000: result.ctrl.alu_op = ALU_NOR;
            17'b0000000000_0101001: result.ctrl.alu_op = ALU_AND;
            17'b0000000000_0101010: result.ctrl.alu_op = ALU_OR;
            17'b0000000000_0101011: result.ctrl.alu_op = ALU_XOR;
            17'b0000000000_0101110: result.ctrl.alu_op = ALU_SLL;   // SLL.W
            17'b0000000000_0101111: result.ctrl.alu_op = ALU_SRL;   // SRL.W
            17'b0000000000_0110000: result.ctrl.alu_op = ALU_SRA;   // SRA.W
            17'b0000000001_0000001:                                 // SLLI.W
            begin
                result.ctrl.alu_op = ALU_SLL;
                result.imm         = ui5;
            end
            17'b0000000001_0001001:                                 // SRLI.W
            begin
                result.ctrl.alu_op = ALU_SRL;
                result.imm         = ui5;
            end
            17'b0000000001_0010001:                                 // SRAI.W
            begin
                result.ctrl.alu_op = ALU_SRA;
                result.imm         = ui5;
            end
            17'b0000001000_???????:                                 // SLTI
            begin
                result.ctrl.alu_op = ALU_SLT;
                result.imm         = si12;
            end
            17'b0000001001_???????:                                 // SLTUI
            begin
                result.ctrl.alu_op = ALU_SLTU;
                result.imm         = si12;
            end
            17'b0000001010_???????:                                 // ADDI.W
            begin
                result.ctrl.alu_op = ALU_ADD;
                result.imm         = si12;
            end
            17'b0000001101_???????:                                 // ANDI
            begin
                result.ctrl.alu_op = ALU_AND;
                result.imm         = ui12;
            end
            17'b0000001110_???????:                                 // ORI
            begin
                result.ctrl.alu_op = ALU_OR;
                result.imm         = ui12;
            end
            17'b0000001111_???????:                                 // XORI
            begin
                result.ctrl.alu_op = ALU_XOR;
                result.imm         = ui12;
            end
            17'b0001010_??????????:                                 // LU12I.W
            begin
                result.ctrl.alu_op = ALU_PASS2;
                result.imm         = ui20;
                result.rj          = '0;
            end
            17'b0001110_??????????:                                 // PCADDU12I
            begin
                result.ctrl.alu_op = ALU_ADD;
                result.ctrl.src1   = SRC1_PC;
                result.imm         = ui20;
                result.rj          = '0;
            end
            default: result = '0;
        endcase
        // Three-register forms read rk instead of an immediate
        if (result.hit && ir[31:22] == 10'b0)
        begin
            result.rk        = ir[14:10];
            result.ctrl.src2 = SRC2_REG;
        end
    end

endmodule

// ==== verilog/branch_decode.sv ====
`timescale 1ns/10ps

module branch_decode
    import decode_pkg::*;
(
    input  inst_t      ir,
    output class_out_t result
);

    imm_t offs16;
    imm_t offs26;
    logic link;

    assign offs16 = {{14{ir[25]}}, ir[25:10], 2'b00};
    assign offs26 = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};   // High part sits in rj/rd

    always_comb
    begin
        result               = '0;
        link                 = 1'b0;
        result.hit           = 1'b1;
        result.ctrl.unit     = UNIT_BRANCH;
        result.ctrl.redirect = 1'b1;
        result.ctrl.src2     = SRC2_RD;
        result.ctrl.sub_op   = ir[29:26] - 4'd5;   // BEQ..BGEU give 1..6
        result.imm           = offs16;
        result.rj            = ir[9:5];
        result.rd            = ir[4:0];
        case (ir[31:26])
            6'b010011: link = 1'b1;                 // JIRL
            6'b010100:                              // B
            begin
                result.ctrl.sub_op = '0;
                result.ctrl.src2   = SRC2_REG;
                result.imm         = offs26;
                result.rj          = '0;
                result.rd          = '0;
            end
            6'b010101:                              // BL
            begin
                link       = 1'b1;
                result.imm = offs26;
                result.rj  = '0;
                result.rd  = LINK_REG;
            end
            6'b010110, 6'b010111: result.ctrl.alu_op = ALU_SUB;    // BEQ, BNE
            6'b011000, 6'b011001: result.ctrl.alu_op = ALU_SLT;    // BLT, BGE
            6'b011010, 6'b011011: result.ctrl.alu_op = ALU_SLTU;   // BLTU, BGEU
            default: result.hit = 1'b0;
        endcase
        if (link)
        begin
            result.ctrl.unit      = UNIT_LINK;
            result.ctrl.sub_op    = {3'b000, ir[28]};   // JIRL 0, BL 1
            result.ctrl.reg_write = 1'b1;
            result.ctrl.alu_op    = ALU_ADD;            // rd gets pc + 4
            result.ctrl.src1      = SRC1_PC;
            result.ctrl.src2      = SRC2_FOUR;
        end
        if (!result.hit)
            result = '0;
    end

endmodule

// ==== verilog/mem_decode.sv ====
`timescale 1ns/10ps

module mem_decode
    import decode_pkg::*;
(
    input  inst_t      ir,
    output class_out_t result
);

    logic    known;
    logic    store;
    sub_op_t sub;

    always_comb
    begin
        known = 1'b1;
        store = 1'b0;
        sub   = '0;
        case (ir[25:22])
            4'b0000: sub = 4'd0;                    // LD.B
            4'b0001: sub = 4'd1;                    // LD.H
            4'b0010: sub = 4'd2;                    // LD.W
            4'b0100:                                // ST.B
            begin
                sub   = 4'd3;
                store = 1'b1;
            end
            4'b0101:                                // ST.H
            begin
                sub   = 4'd4;
                store = 1'b1;
            end
            4'b0110:                                // ST.W
            begin
                sub   = 4'd5;
                store = 1'b1;
            end
            4'b1000: sub = 4'd6;                    // LD.BU
            4'b1001: sub = 4'd7;                    // LD.HU
            default: known = 1'b0;                  // PRELD and holes
        endcase
    end

    always_comb
    begin
        result = '0;
        if (known && ir[31:26] == OP_MEM)
        begin
            result.hit            = 1'b1;
            result.ctrl.unit      = UNIT_MEM;
            result.ctrl.sub_op    = sub;
            result.ctrl.mem_read  = !store;
            result.ctrl.reg_write = !store;
            result.ctrl.mem_write = store;
            result.imm            = {{20{ir[21]}}, ir[21:10]};
            result.rj             = ir[9:5];
            result.rd             = ir[4:0];      // Store data for ST.*
        end
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  inst_t       ir,
    input  addr_t       pc,
    input  class_out_t  alu_res,
    input  class_out_t  br_res,
    input  class_out_t  mem_res,
    output logic        out_valid,
    output decode_out_t out
);

    class_out_t  hit_res;
    logic        any_hit;
    logic        is_sys;
    logic        is_brk;
    decode_out_t nxt;

    function automatic decode_out_t excp_line(excp_code_t code, logic sub);
        decode_out_t o;
        o             = '0;
        o.ctrl.unit   = UNIT_EXCP;
        o.excp_code   = code;
        o.excp_sub    = sub;
        return o;
    endfunction

    assign any_hit = alu_res.hit | br_res.hit | mem_res.hit;
    assign is_sys  = (ir[31:15] == OP_SYSCALL);
    assign is_brk  = (ir[31:15] == OP_BREAK);

    always_comb
    begin
        if (br_res.hit)
            hit_res = br_res;
        else if (mem_res.hit)
            hit_res = mem_res;
        else
            hit_res = alu_res;
    end

    always_comb
    begin
        nxt = '0;
        if (pc[1:0] != 2'b00)
            nxt = excp_line(ECODE_ADE, 1'b0);       // ADEF
        else if (pc[31])
            nxt = excp_line(ECODE_ADE, 1'b1);       // ADEM
        else if (any_hit)
        begin
            nxt.ctrl = hit_res.ctrl;
            nxt.imm  = hit_res.imm;
            nxt.rj   = hit_res.rj;
            nxt.rk   = hit_res.rk;
            nxt.rd   = hit_res.rd;
        end
        else if (is_sys)
            nxt = excp_line(ECODE_SYS, 1'b0);
        else if (is_brk)
            nxt = excp_line(ECODE_BRK, 1'b0);
        else if (ir == '0)
            nxt.nop = 1'b1;                         // All-zero word is a no-op
        else
            nxt = excp_line(ECODE_INE, 1'b0);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            out       <= '0;
        end
        else
        begin
            out_valid <= in_valid;
            if (in_valid)
                out <= nxt;                         // Hold last result when idle
        end
    end

    a_class_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> $onehot0({alu_res.hit, br_res.hit, mem_res.hit}));

    a_idle_after_reset: assert property (@(posedge clk)
        !rst_n |=> !out_valid);

    a_nop_ctrl_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out.nop) |-> (out.ctrl == '0 && out.excp_code == '0));

endmodule

// ==== verilog/decoder_top.sv ====
`timescale 1ns/10ps

module decoder_top
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  inst_t       ir,
    input  addr_t       pc,
    output logic        out_valid,
    output decode_out_t out
);

    class_out_t alu_res;
    class_out_t br_res;
    class_out_t mem_res;

    alu_decode i_alu_decode (
        .ir     (ir),
        .result (alu_res)
    );

    branch_decode i_branch_decode (
        .ir     (ir),
        .result (br_res)
    );

    mem_decode i_mem_decode (
        .ir     (ir),
        .result (mem_res)
    );

    decode_stage i_decode_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .ir        (ir),
        .pc        (pc),
        .alu_res   (alu_res),
        .br_res    (br_res),
        .mem_res   (mem_res),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

// ==== include/decoder_ref.svh ====
`ifndef DECODER_REF_SVH
`define DECODER_REF_SVH

function automatic decode_out_t ref_excp(excp_code_t code, logic sub);
    decode_out_t r;
    r           = '0;
    r.ctrl.unit = UNIT_EXCP;
    r.excp_code = code;
    r.excp_sub  = sub;
    return r;
endfunction

function automatic decode_out_t ref_decode(inst_t ir, addr_t pc);
    decode_out_t r;
    logic [5:0]  op6;
    r   = '0;
    op6 = ir[31:26];
    if (pc[1:0] != 2'b00 || pc[31])
        return ref_excp(ECODE_ADE, pc[1:0] == 2'b00);
    if (ir == '0)
    begin
        r.nop = 1'b1;
        return r;
    end
    r.rj             = ir[9:5];
    r.rd             = ir[4:0];
    r.ctrl.reg_write = 1'b1;
    r.ctrl.src2      = SRC2_IMM;
    if (ir[31:22] == 10'h000)
    begin
        r.rk        = ir[14:10];
        r.ctrl.src2 = SRC2_REG;
        case (ir[21:15])
            7'h20: r.ctrl.alu_op = ALU_ADD;
            7'h22: r.ctrl.alu_op = ALU_SUB;
            7'h24: r.ctrl.alu_op = ALU_SLT;
            7'h25: r.ctrl.alu_op = ALU_SLTU;
            7'h28: r.ctrl.alu_op = ALU_NOR;
            7'h29: r.ctrl.alu_op = ALU_AND;
            7'h2a: r.ctrl.alu_op = ALU_OR;
            7'h2b: r.ctrl.alu_op = ALU_XOR;
            7'h2e: r.ctrl.alu_op = ALU_SLL;
            7'h2f: r.ctrl.alu_op = ALU_SRL;
            7'h30: r.ctrl.alu_op = ALU_SRA;
            7'h56: return ref_excp(ECODE_SYS, 1'b0);
            7'h54: return ref_excp(ECODE_BRK, 1'b0);
            default: return ref_excp(ECODE_INE, 1'b0);
        endcase
        return r;
    end
    if (ir[31:22] == 10'h001)
    begin
        r.imm = {27'b0, ir[14:10]};
        case (ir[21:15])
            7'h01: r.ctrl.alu_op = ALU_SLL;
            7'h09: r.ctrl.alu_op = ALU_SRL;
            7'h11: r.ctrl.alu_op = ALU_SRA;
            default: return ref_excp(ECODE_INE, 1'b0);
        endcase
        return r;
    end
    if (ir[31:25] == 7'h01)
    begin
        r.imm = ir[24] ? {20'b0, ir[21:10]} : {{20{ir[21]}}, ir[21:10]};
        case (ir[24:22])
            3'd0: r.ctrl.alu_op = ALU_SLT;
            3'd1: r.ctrl.alu_op = ALU_SLTU;
            3'd2: r.ctrl.alu_op = ALU_ADD;
            3'd5: r.ctrl.alu_op = ALU_AND;
            3'd6: r.ctrl.alu_op = ALU_OR;
            3'd7: r.ctrl.alu_op = ALU_XOR;
            default: return ref_excp(ECODE_INE, 1'b0);
        endcase
        return r;
    end
    if (ir[31:25] == 7'h0a || ir[31:25] == 7'h0e)
    begin
        r.rj          = '0;
        r.imm         = {ir[24:5], 12'b0};
        r.ctrl.alu_op = ir[27] ? ALU_ADD : ALU_PASS2;
        r.ctrl.src1   = ir[27] ? SRC1_PC : SRC1_REG;
        return r;
    end
    if (op6 == 6'h0a)
    begin
        r.ctrl.unit = UNIT_MEM;
        r.imm       = {{20{ir[21]}}, ir[21:10]};
        case (ir[25:22])
            4'd0, 4'd1, 4'd2: r.ctrl.sub_op = ir[25:22];
            4'd8, 4'd9: r.ctrl.sub_op = ir[25:22] - 4'd2;
            4'd4, 4'd5, 4'd6:
            begin
                r.ctrl.sub_op    = ir[25:22] - 4'd1;
                r.ctrl.reg_write = 1'b0;
            end
            default: return ref_excp(ECODE_INE, 1'b0);
        endcase
        r.ctrl.src2      = SRC2_REG;
        r.ctrl.mem_read  = r.ctrl.reg_write;
        r.ctrl.mem_write = !r.ctrl.reg_write;
        return r;
    end
    if (op6 >= 6'h13 && op6 <= 6'h1b)
    begin
        r.ctrl.unit      = UNIT_BRANCH;
        r.ctrl.redirect  = 1'b1;
        r.ctrl.reg_write = 1'b0;
        r.ctrl.src2      = SRC2_RD;
        r.ctrl.sub_op    = sub_op_t'(op6 - 6'h15);
        r.imm            = {{14{ir[25]}}, ir[25:10], 2'b00};
        if (op6 >= 6'h1a)
            r.ctrl.alu_op = ALU_SLTU;
        else if (op6 >= 6'h18)
            r.ctrl.alu_op = ALU_SLT;
        else if (op6 >= 6'h16)
            r.ctrl.alu_op = ALU_SUB;
        if (op6 == 6'h14 || op6 == 6'h15)
        begin
            r.imm         = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};
            r.rj          = '0;
            r.rd          = (op6 == 6'h15) ? 5'd1 : 5'd0;
            r.ctrl.sub_op = '0;
            r.ctrl.src2   = SRC2_REG;
        end
        if (op6 == 6'h13 || op6 == 6'h15)
        begin
            r.ctrl.unit      = UNIT_LINK;
            r.ctrl.sub_op    = (op6 == 6'h15) ? 4'd1 : 4'd0;
            r.ctrl.reg_write = 1'b1;
            r.ctrl.alu_op    = ALU_ADD;
            r.ctrl.src1      = SRC1_PC;
            r.ctrl.src2      = SRC2_FOUR;
        end
        return r;
    end
    return ref_excp(ECODE_INE, 1'b0);
endfunction

function automatic inst_t enc_3r(logic [16:0] op, reg_idx_t rk, reg_idx_t rj, reg_idx_t rd);
    return {op, rk, rj, rd};
endfunction

function automatic inst_t enc_2ri12(logic [9:0] op, logic [11:0] imm, reg_idx_t rj,
                                   reg_idx_t rd);
    return {op, imm, rj, rd};
endfunction

function automatic inst_t enc_2ri16(logic [5:0] op, logic [15:0] offs, reg_idx_t rj,
                                   reg_idx_t rd);
    return {op, offs, rj, rd};
endfunction

function automatic inst_t enc_i26(logic [5:0] op, logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};
endfunction

function automatic inst_t enc_1ri20(logic [6:0] op, logic [19:0] imm, reg_idx_t rd);
    return {op, imm, rd};
endfunction

`endif

// ==== tests/decoder_tb.sv ====
`timescale 1ns/10ps

module decoder_tb
    import decode_pkg::*;
();

    `include "decoder_ref.svh"

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    inst_t       ir;
    addr_t       pc;
    logic        out_valid;
    decode_out_t out;

    decode_out_t exp_q[$];                  // Expected results in issue order
    int          cyc_q[$];                  // Cycle each input was driven
    inst_t       ir_q[$];
    inst_t       pool[$];                   // Words reused by the stream test
    int          cycle;
    integer      seed;
    logic [31:0] rnd;
    int          ctrl_errs;
    int          field_errs;
    int          excp_errs;
    int          flow_errs;

    logic [16:0] ops_3r[11] = '{17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29,
                                17'h2a, 17'h2b, 17'h2e, 17'h2f, 17'h30};
    logic [16:0] ops_sh[3]  = '{17'h81, 17'h89, 17'h91};   // SLLI.W, SRLI.W, SRAI.W
    logic [9:0]  ops_i12[6] = '{10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f};
    logic [5:0]  ops_b16[7] = '{6'h13, 6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b};
    logic [3:0]  mem_subs[8] = '{4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd6, 4'd8, 4'd9};

    decoder_top i_decoder_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .ir        (ir),
        .pc        (pc),
        .out_valid (out_valid),
        .out       (out)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic addr_t aligned_pc(logic [31:0] raw);
        return {1'b0, raw[30:2], 2'b00};
    endfunction

    task automatic roll();
        rnd = $random(seed);
    endtask

    task automatic send(inst_t word, addr_t addr);
        @(negedge clk);
        in_valid = 1'b1;
        ir       = word;
        pc       = addr;
        exp_q.push_back(ref_decode(word, addr));
        cyc_q.push_back(cycle);
        ir_q.push_back(word);
        pool.push_back(word);
    endtask

    task automatic idle(int n);
        repeat (n)
        begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic check_ctrl(inst_t word, decode_ctrl_t got, logic got_nop,
                              decode_ctrl_t want, logic want_nop);
        if (got !== want || got_nop !== want_nop)
        begin
            ctrl_errs++;
            $display("ERR %0t: ir %h ctrl %h nop %b, expected ctrl %h nop %b",
                     $time, word, got, got_nop, want, want_nop);
        end
    endtask

    task automatic check_fields(inst_t word, reg_idx_t got_rj, reg_idx_t got_rk,
                                reg_idx_t got_rd, imm_t got_imm, reg_idx_t want_rj,
                                reg_idx_t want_rk, reg_idx_t want_rd, imm_t want_imm);
        if (got_rj !== want_rj || got_rk !== want_rk || got_rd !== want_rd
            || got_imm !== want_imm)
        begin
            field_errs++;
            $display("ERR %0t: ir %h rj/rk/rd %0d/%0d/%0d imm %h, expected %0d/%0d/%0d imm %h",
                     $time, word, got_rj, got_rk, got_rd, got_imm,
                     want_rj, want_rk, want_rd, want_imm);
        end
    endtask

    task automatic check_excp(inst_t word, excp_code_t got, logic got_sub,
                              excp_code_t want, logic want_sub);
        if (got !== want || got_sub !== want_sub)
        begin
            excp_errs++;
            $display("ERR %0t: ir %h excp %0d sub %b, expected excp %0d sub %b",
                     $time, word, got, got_sub, want, want_sub);
        end
    endtask

    // One expected entry per valid output, half a cycle after the register updates
    always @(negedge clk)
    begin : compare_out
        decode_out_t want;
        int          sent;
        inst_t       word;
        if (out_valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                flow_errs++;
                $display("ERR %0t: out_valid high with no input pending", $time);
            end
            else
            begin
                want = exp_q.pop_front();
                sent = cyc_q.pop_front();
                word = ir_q.pop_front();
                if (cycle != sent + 1)
                begin
                    flow_errs++;
                    $display("ERR %0t: ir %h came out after %0d cycles instead of 1",
                             $time, word, cycle - sent);
                end
                check_ctrl(word, out.ctrl, out.nop, want.ctrl, want.nop);
                check_fields(word, out.rj, out.rk, out.rd, out.imm,
                             want.rj, want.rk, want.rd, want.imm);
                check_excp(word, out.excp_code, out.excp_sub, want.excp_code, want.excp_sub);
            end
        end
        else if (out_valid !== 1'b0)
        begin
            flow_errs++;
            $display("ERR %0t: out_valid is unknown", $time);
        end
        else if (exp_q.size() != 0 && cyc_q[0] + 1 <= cycle)
        begin
            flow_errs++;
            word = ir_q.pop_front();
            void'(exp_q.pop_front());
            void'(cyc_q.pop_front());
            $display("ERR %0t: no output for ir %h", $time, word);
        end
    end

    initial
    begin
        int waited;
        seed       = 16;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        ir         = '0;
        pc         = '0;
        cycle      = 0;
        ctrl_errs  = 0;
        field_errs = 0;
        excp_errs  = 0;
        flow_errs  = 0;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        idle(2);                                // out_valid must stay low here

        foreach (ops_3r[i])
        begin
            roll();
            send(enc_3r(ops_3r[i], rnd[14:10], rnd[9:5], rnd[4:0]), aligned_pc(rnd));
        end
        foreach (ops_sh[i])
        begin
            roll();
            send(enc_3r(ops_sh[i], rnd[14:10], rnd[9:5], rnd[4:0]), aligned_pc(rnd));
        end
        foreach (ops_i12[i])
        begin
            roll();
            send(enc_2ri12(ops_i12[i], rnd[26:15], rnd[9:5], rnd[4:0]), aligned_pc(rnd));
            send(enc_2ri12(ops_i12[i], 12'h800, rnd[14:10], rnd[4:0]), aligned_pc(rnd));
            send(enc_2ri12(ops_i12[i], 12'hfff, rnd[9:5], rnd[14:10]), aligned_pc(rnd));
        end
        roll();
        send(enc_1ri20(7'h0a, rnd[19:0], rnd[24:20]), aligned_pc(rnd));   // LU12I.W
        send(enc_1ri20(7'h0e, rnd[31:12], rnd[4:0]), aligned_pc(rnd));    // PCADDU12I

        foreach (ops_b16[i])
        begin
            roll();
            send(enc_2ri16(ops_b16[i], rnd[31:16], rnd[9:5], rnd[4:0]), aligned_pc(rnd));
            send(enc_2ri16(ops_b16[i], 16'h8000, rnd[14:10], rnd[4:0]), aligned_pc(rnd));
            send(enc_2ri16(ops_b16[i], 16'hfffc, rnd[9:5], rnd[14:10]), aligned_pc(rnd));
        end
        for (int i = 0; i < 3; i++)
        begin
            roll();
            send(enc_i26(6'h14, rnd[25:0]), aligned_pc(rnd));               // B
            send(enc_i26(6'h15, rnd[31:6]), aligned_pc(rnd));               // BL
        end
        send(enc_i26(6'h14, 26'h2000000), aligned_pc(rnd));                // Farthest back
        send(enc_i26(6'h15, 26'h3ffffff), aligned_pc(rnd));

        foreach (mem_subs[i])
        begin
            roll();
            send(enc_2ri12({6'h0a, mem_subs[i]}, rnd[26:15], rnd[9:5], rnd[4:0]),
                 aligned_pc(rnd));
            send(enc_2ri12({6'h0a, mem_subs[i]}, 12'h9f0, rnd[14:10], rnd[4:0]),
                 aligned_pc(rnd));
        end

        roll();
        send(enc_3r(17'h20, rnd[14:10], rnd[9:5], rnd[4:0]), {1'b0, rnd[30:2], 2'b01});
        send(enc_3r(17'h20, rnd[14:10], rnd[9:5], rnd[4:0]), {1'b0, rnd[30:2], 2'b10});
        send(enc_3r(17'h2a, rnd[14:10], rnd[9:5], rnd[4:0]), {1'b1, rnd[30:2], 2'b00});
        send(enc_3r(17'h2a, rnd[14:10], rnd[9:5], rnd[4:0]), {1'b1, rnd[30:2], 2'b11});
        send(enc_3r(17'h56, rnd[14:10], rnd[9:5], rnd[4:0]), aligned_pc(rnd));  // SYSCALL
        send(enc_3r(17'h54, rnd[4:0], rnd[9:5], rnd[14:10]), aligned_pc(rnd));  // BREAK
        send(enc_3r(17'h38, rnd[14:10], rnd[9:5], rnd[4:0]), aligned_pc(rnd));  // MUL.W
        send({8'h04, rnd[13:0], 5'd0, rnd[4:0]}, aligned_pc(rnd));              // CSRRD
        send({8'h20, rnd[13:0], rnd[9:5], rnd[4:0]}, aligned_pc(rnd));          // LL.W
        send({17'h070e4, rnd[14:0]}, aligned_pc(rnd));                          // DBAR
        send({6'h3f, rnd[25:0]}, aligned_pc(rnd));
        for (int i = 0; i < 16; i++)
        begin
            roll();
            send(rnd, aligned_pc($random(seed)));
        end
        send(32'h0, aligned_pc(rnd));           // No-op
        idle(3);

        // Back-to-back stream with random idle gaps
        for (int i = 0; i < 60; i++)
        begin
            roll();
            send(pool[rnd[15:0] % pool.size()], aligned_pc($random(seed)));
            if (rnd[23:22] == 2'b00)
                idle(1 + rnd[24]);
        end
        idle(1);

        waited = 0;
        while (exp_q.size() != 0 && waited < 20)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            flow_errs++;
            $display("Timeout: %0d expected outputs never appeared", exp_q.size());
        end
        idle(2);

        $display("Errors: ctrl %0d, fields %0d, excp %0d, flow %0d",
                 ctrl_errs, field_errs, excp_errs, flow_errs);
        if (ctrl_errs + field_errs + excp_errs + flow_errs == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== decoder.f ====
+incdir+include
verilog/decode_pkg.sv
verilog/alu_decode.sv
verilog/branch_decode.sv
verilog/mem_decode.sv
verilog/decode_stage.sv
verilog/decoder_top.sv
tests/decoder_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f decoder.f \
    --top-module decoder_tb \
    -o decoder_sim

sim_out=$(./obj_dir/decoder_sim)
echo "$sim_out"

if grep -qx "PASS: all tests" <<< "$sim_out"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
